// File: verilog.f
+incdir+.
bcu_pkg.sv
flag_capture.sv
condition_predicate.sv
branch_resolve.sv
branch_condition_unit.sv
branch_condition_unit_chk.sv
tb_branch_condition_unit.sv

// File: Bender.yml
package:
  name: branch_condition_unit

sources:
  - include_dirs:
      - .
    files:
      - bcu_pkg.sv
      - flag_capture.sv
      - condition_predicate.sv
      - branch_resolve.sv
      - branch_condition_unit.sv
  - target: test
    include_dirs:
      - .
    files:
      - branch_condition_unit_chk.sv
      - tb_branch_condition_unit.sv

// File: tb_branch_condition_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "bcu_cfg.svh"

module tb_branch_condition_unit
    import bcu_pkg::*;
();

    // cycle budget of each test, with the timeout a margin above their sum
    localparam int RESET_CYCLES   = 8;
    localparam int T1_CYCLES      = 6;
    localparam int T2_CYCLES      = 200 * 3;
    localparam int T3_CYCLES      = 24;
    localparam int T4_CYCLES      = 90;
    localparam int T5_CYCLES      = 8;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + T1_CYCLES + T2_CYCLES + T3_CYCLES
                                  + T4_CYCLES + T5_CYCLES + 200;

    logic                         clock = 1'b0;
    logic                         arst_n = 1'b0;
    logic                         alu_valid;
    logic [`BCU_WORD_WIDTH-1:0]   alu_result;
    logic                         alu_carryout;
    logic                         alu_overflow;
    logic                         ext_a;
    logic                         ext_b;
    logic                         cmd_valid;
    cmd_kind_e                    cmd_kind;
    cmd_word_u                    cmd_word;
    logic                         branch_taken;
    logic                         branch_not_taken;
    logic [`BCU_TARGET_WIDTH-1:0] branch_target;

    // reference model state
    logic                          m_negative;
    logic                          m_carryout;
    logic                          m_lessthan;
    logic                          m_match_a;
    logic                          m_match_b;
    logic [`BCU_WORD_WIDTH-1:0]    m_sentinel_a;
    logic [`BCU_WORD_WIDTH-1:0]    m_sentinel_b;
    logic [`BCU_COUNTER_WIDTH-1:0] m_count;
    logic                          exp_taken;
    logic                          exp_not_taken;
    logic [`BCU_TARGET_WIDTH-1:0]  exp_target;

    int seed = 70684;
    int cycles = 0;
    int model_checks = 0;
    int model_errors = 0;
    int task_checks = 0;
    int task_errors = 0;
    int tests_run = 0;
    int tests_failed = 0;

    always #10 clock = ~clock;

    branch_condition_unit u_dut (
        .clock            (clock),
        .arst_n           (arst_n),
        .alu_valid        (alu_valid),
        .alu_result       (alu_result),
        .alu_carryout     (alu_carryout),
        .alu_overflow     (alu_overflow),
        .ext_a            (ext_a),
        .ext_b            (ext_b),
        .cmd_valid        (cmd_valid),
        .cmd_kind         (cmd_kind),
        .cmd_word         (cmd_word),
        .branch_taken     (branch_taken),
        .branch_not_taken (branch_not_taken),
        .branch_target    (branch_target)
    );

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------

    function automatic logic [`BCU_WORD_WIDTH-1:0] rand_word();
        logic [31:0] r;
        r = $random(seed);
        return r[`BCU_WORD_WIDTH-1:0];
    endfunction

    function automatic logic rand_bit();
        logic [31:0] r;
        r = $random(seed);
        return r[0];
    endfunction

    // group A order is negative, carry, sentinel A, external A
    // and group B order is less-than, counter zero, sentinel B, external B
    function automatic logic expected_predicate(input cond_fields_t c);
        logic       a_flag;
        logic       b_flag;
        logic [1:0] idx;
        case (c.a_sel)
            2'd0:    a_flag = m_negative;
            2'd1:    a_flag = m_carryout;
            2'd2:    a_flag = m_match_a;
            default: a_flag = ext_a;
        endcase
        case (c.b_sel)
            2'd0:    b_flag = m_lessthan;
            2'd1:    b_flag = (m_count == '0);
            2'd2:    b_flag = m_match_b;
            default: b_flag = ext_b;
        endcase
        // the truth table is addressed by 2*a + b
        idx = {a_flag, b_flag};
        return c.op[idx];
    endfunction

    // reads the inputs as they stand before this edge's stimulus update
    always @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            m_negative    <= 1'b0;
            m_carryout    <= 1'b0;
            m_lessthan    <= 1'b0;
            m_match_a     <= 1'b0;
            m_match_b     <= 1'b0;
            m_sentinel_a  <= '0;
            m_sentinel_b  <= '0;
            m_count       <= '0;
            exp_taken     <= 1'b0;
            exp_not_taken <= 1'b0;
            exp_target    <= '0;
        end else begin
            if (alu_valid) begin
                m_negative <= alu_result[`BCU_WORD_WIDTH-1];
                m_carryout <= alu_carryout;
                m_lessthan <= alu_result[`BCU_WORD_WIDTH-1] ^ alu_overflow;
                m_match_a  <= (alu_result == m_sentinel_a);
                m_match_b  <= (alu_result == m_sentinel_b);
            end
            if (cmd_valid && cmd_kind == LOAD_SENTINEL_A) begin
                m_sentinel_a <= cmd_word.payload;
            end
            if (cmd_valid && cmd_kind == LOAD_SENTINEL_B) begin
                m_sentinel_b <= cmd_word.payload;
            end
            if (cmd_valid && cmd_kind == LOAD_COUNTER) begin
                m_count <= cmd_word.payload;
            end else if (m_count != '0) begin
                m_count <= m_count - 16'd1;
            end
            exp_taken     <= cmd_valid && cmd_kind == EVAL && expected_predicate(cmd_word.cond);
            exp_not_taken <= cmd_valid && cmd_kind == EVAL && !expected_predicate(cmd_word.cond);
            if (cmd_valid && cmd_kind == EVAL) begin
                exp_target <= cmd_word.cond.target;
            end
        end
    end

    // outputs are compared in the middle of the cycle where they are stable
    always @(negedge clock) begin
        if (arst_n) begin
            model_checks = model_checks + 3;
            assert (branch_taken === exp_taken) else begin
                $display("FAIL at %0t ns: branch_taken expected %b, actual %b",
                         $time, exp_taken, branch_taken);
                model_errors++;
            end
            assert (branch_not_taken === exp_not_taken) else begin
                $display("FAIL at %0t ns: branch_not_taken expected %b, actual %b",
                         $time, exp_not_taken, branch_not_taken);
                model_errors++;
            end
            assert (branch_target === exp_target) else begin
                $display("FAIL at %0t ns: branch_target expected %h, actual %h",
                         $time, exp_target, branch_target);
                model_errors++;
            end
        end
    end

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not complete within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // stimulus tasks
    // ------------------------------------------------------------

    // carry, overflow and the external levels are random on every cycle
    task automatic drive_cycle(input logic alu_v, input logic [`BCU_WORD_WIDTH-1:0] result,
                               input logic cmd_v, input cmd_kind_e kind,
                               input logic [`BCU_WORD_WIDTH-1:0] word);
        @(posedge clock);
        alu_valid    <= alu_v;
        alu_result   <= result;
        alu_carryout <= rand_bit();
        alu_overflow <= rand_bit();
        ext_a        <= rand_bit();
        ext_b        <= rand_bit();
        cmd_valid    <= cmd_v;
        cmd_kind     <= kind;
        cmd_word     <= word;
    endtask

    task automatic idle_cycle();
        drive_cycle(1'b0, '0, 1'b0, EVAL, '0);
    endtask

    task automatic alu_cycle(input logic [`BCU_WORD_WIDTH-1:0] result);
        drive_cycle(1'b1, result, 1'b0, EVAL, '0);
    endtask

    task automatic cmd_cycle(input cmd_kind_e kind, input logic [`BCU_WORD_WIDTH-1:0] word);
        drive_cycle(1'b0, '0, 1'b1, kind, word);
    endtask

    function automatic logic [`BCU_WORD_WIDTH-1:0] eval_word(input logic [1:0] a_sel,
            input logic [1:0] b_sel, input logic [3:0] op, input logic [7:0] target);
        cond_fields_t f;
        f.a_sel  = a_sel;
        f.b_sel  = b_sel;
        f.op     = op;
        f.target = target;
        return f;
    endfunction

    // the pulse sits in the cycle after the edge that captured the eval
    task automatic expect_pulse(input logic want_taken, input logic [7:0] want_target);
        @(negedge clock);
        task_checks = task_checks + 2;
        assert (branch_taken === want_taken) else begin
            $display("FAIL at %0t ns: branch_taken expected %b, actual %b",
                     $time, want_taken, branch_taken);
            task_errors++;
        end
        assert (branch_target === want_target) else begin
            $display("FAIL at %0t ns: branch_target expected %h, actual %h",
                     $time, want_target, branch_target);
            task_errors++;
        end
    endtask

    task automatic eval_expect(input logic [1:0] a_sel, input logic [1:0] b_sel,
                               input logic [3:0] op, input logic want_taken);
        logic [`BCU_WORD_WIDTH-1:0] r;
        r = rand_word();
        cmd_cycle(EVAL, eval_word(a_sel, b_sel, op, r[7:0]));
        idle_cycle();
        expect_pulse(want_taken, r[7:0]);
    endtask

    // 4'b1100 passes the A flag and 4'b1010 passes the B flag
    task automatic sentinel_case(input logic [`BCU_WORD_WIDTH-1:0] result,
                                 input logic want_a, input logic want_b);
        alu_cycle(result);
        eval_expect(2'd2, 2'd0, 4'b1100, want_a);
        eval_expect(2'd0, 2'd2, 4'b1010, want_b);
    endtask

    function automatic int total_errors();
        return model_errors + task_errors + u_dut.u_chk.fail_count;
    endfunction

    task automatic finish_test(input string name, input int start_errors);
        tests_run++;
        if (total_errors() == start_errors) begin
            $display("test %0s: passed", name);
        end else begin
            $display("test %0s: failed with %0d errors", name, total_errors() - start_errors);
            tests_failed++;
        end
    endtask

    // ------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------

    initial begin
        int                         start;
        int                         counts [4];
        logic [`BCU_WORD_WIDTH-1:0] sa;
        logic [`BCU_WORD_WIDTH-1:0] sb;
        logic [`BCU_WORD_WIDTH-1:0] other;
        logic [`BCU_WORD_WIDTH-1:0] r;
        alu_valid    = 1'b0;
        alu_result   = '0;
        alu_carryout = 1'b0;
        alu_overflow = 1'b0;
        ext_a        = 1'b0;
        ext_b        = 1'b0;
        cmd_valid    = 1'b0;
        cmd_kind     = EVAL;
        cmd_word     = '0;
        counts       = '{0, 1, 3, 5};
        repeat (RESET_CYCLES) @(posedge clock);
        arst_n <= 1'b1;

        // counter is zero out of reset so the counter flag reads 1
        start = total_errors();
        idle_cycle();
        idle_cycle();
        @(negedge clock);
        task_checks = task_checks + 3;
        assert (branch_taken === 1'b0) else begin
            $display("FAIL at %0t ns: branch_taken expected 0, actual %b",
                     $time, branch_taken);
            task_errors++;
        end
        assert (branch_not_taken === 1'b0) else begin
            $display("FAIL at %0t ns: branch_not_taken expected 0, actual %b",
                     $time, branch_not_taken);
            task_errors++;
        end
        assert (branch_target === '0) else begin
            $display("FAIL at %0t ns: branch_target expected 00, actual %h",
                     $time, branch_target);
            task_errors++;
        end
        eval_expect(2'd0, 2'd1, 4'b1010, 1'b1);
        finish_test("reset state", start);

        // random flags and random conditions, checked by the model
        start = total_errors();
        for (int i = 0; i < 200; i++) begin
            alu_cycle(rand_word());
            r = rand_word();
            cmd_cycle(EVAL, r);
            idle_cycle();
            @(negedge clock);
            task_checks++;
            assert (branch_taken ^ branch_not_taken) else begin
                $display("no single decision pulse followed eval number %0d", i);
                task_errors++;
            end
        end
        finish_test("comparisons", start);

        start = total_errors();
        sa = rand_word();
        sb = rand_word();
        if (sb == sa) begin
            sb = ~sa;
        end
        other = rand_word();
        while (other == sa || other == sb) begin
            other = other + 16'd1;
        end
        cmd_cycle(LOAD_SENTINEL_A, sa);
        cmd_cycle(LOAD_SENTINEL_B, sb);
        sentinel_case(sa, 1'b1, 1'b0);
        sentinel_case(sb, 1'b0, 1'b1);
        sentinel_case(other, 1'b0, 1'b0);
        finish_test("sentinels", start);

        // with k idle cycles between load and eval the counter reads zero when k >= n
        start = total_errors();
        for (int i = 0; i < 4; i++) begin
            for (int k = 0; k <= counts[i] + 1; k++) begin
                cmd_cycle(LOAD_COUNTER, 16'(counts[i]));
                repeat (k) idle_cycle();
                eval_expect(2'd0, 2'd1, 4'b1010, k >= counts[i]);
            end
        end
        finish_test("countdown timer", start);

        // the middle eval shares its cycle with an ALU update and still sees the old flag
        start = total_errors();
        alu_cycle(16'h8000);
        cmd_cycle(EVAL, eval_word(2'd0, 2'd0, 4'b1100, 8'h11));
        drive_cycle(1'b1, 16'h0001, 1'b1, EVAL, eval_word(2'd0, 2'd0, 4'b1100, 8'h22));
        expect_pulse(1'b1, 8'h11);
        cmd_cycle(EVAL, eval_word(2'd0, 2'd0, 4'b1100, 8'h33));
        expect_pulse(1'b1, 8'h22);
        idle_cycle();
        expect_pulse(1'b0, 8'h33);
        idle_cycle();
        finish_test("same-cycle ALU update", start);

        $display("%0d tests run, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, model_checks + task_checks, total_errors());
        if (total_errors() == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: branch_condition_unit_chk.sv
`timescale 1ns/1ns
`default_nettype none

module branch_condition_unit_chk (
    input logic clock,
    input logic arst_n,
    input logic eval,
    input logic branch_taken,
    input logic branch_not_taken
);

    // number of assertion failures seen so far
    int fail_count = 0;

    // ------------------------------------------------------------
    // decision pulse protocol
    // ------------------------------------------------------------

    // taken and not taken are two views of one decision and never overlap
    assert property (@(posedge clock) disable iff (!arst_n)
        !(branch_taken && branch_not_taken))
    else begin
        $error("branch_taken and branch_not_taken are high in the same cycle");
        fail_count++;
    end

    // every eval strobe is answered by exactly one pulse in the next cycle
    assert property (@(posedge clock) disable iff (!arst_n)
        eval |=> (branch_taken != branch_not_taken))
    else begin
        $error("an eval command was not followed by exactly one decision pulse");
        fail_count++;
    end

    // a cycle without eval leaves both pulses low in the next cycle
    assert property (@(posedge clock) disable iff (!arst_n)
        !eval |=> !(branch_taken || branch_not_taken))
    else begin
        $error("a decision pulse appeared without a preceding eval command");
        fail_count++;
    end

    // coming out of reset the outputs start quiet
    assert property (@(posedge clock)
        $rose(arst_n) |-> !(branch_taken || branch_not_taken))
    else begin
        $error("a decision pulse is high right after reset");
        fail_count++;
    end

endmodule

bind branch_condition_unit branch_condition_unit_chk u_chk (
    .clock            (clock),
    .arst_n           (arst_n),
    .eval             (eval),
    .branch_taken     (branch_taken),
    .branch_not_taken (branch_not_taken)
);

`default_nettype wire

// File: branch_condition_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "bcu_cfg.svh"

module branch_condition_unit
    import bcu_pkg::*;
(
    input  logic                         clock,
    input  logic                         arst_n,
    input  logic                         alu_valid,
    input  logic [`BCU_WORD_WIDTH-1:0]   alu_result,
    input  logic                         alu_carryout,
    input  logic                         alu_overflow,
    input  logic                         ext_a,
    input  logic                         ext_b,
    input  logic                         cmd_valid,
    input  cmd_kind_e                    cmd_kind,
    input  cmd_word_u                    cmd_word,
    output logic                         branch_taken,
    output logic                         branch_not_taken,
    output logic [`BCU_TARGET_WIDTH-1:0] branch_target
);

    logic     eval;
    logic     load_counter;
    logic     load_sentinel_a;
    logic     load_sentinel_b;
    flags_a_t flags_a;
    flags_b_t flags_b;
    logic     predicate;

    // ------------------------------------------------------------
    // command decode
    // ------------------------------------------------------------

    // one strobe per command kind, only while cmd_valid is high
    assign eval            = cmd_valid && (cmd_kind == EVAL);
    assign load_counter    = cmd_valid && (cmd_kind == LOAD_COUNTER);
    assign load_sentinel_a = cmd_valid && (cmd_kind == LOAD_SENTINEL_A);
    assign load_sentinel_b = cmd_valid && (cmd_kind == LOAD_SENTINEL_B);

    // ------------------------------------------------------------
    // datapath
    // ------------------------------------------------------------

    // load kinds read the word as a raw payload
    flag_capture u_flag_capture (
        .clock           (clock),
        .arst_n          (arst_n),
        .alu_valid       (alu_valid),
        .alu_result      (alu_result),
        .alu_carryout    (alu_carryout),
        .alu_overflow    (alu_overflow),
        .ext_a           (ext_a),
        .ext_b           (ext_b),
        .load_counter    (load_counter),
        .load_sentinel_a (load_sentinel_a),
        .load_sentinel_b (load_sentinel_b),
        .load_value      (cmd_word.payload),
        .flags_a         (flags_a),
        .flags_b         (flags_b)
    );

    // eval reads the same word as selectors, operator and target
    condition_predicate u_condition_predicate (
        .flags_a   (flags_a),
        .flags_b   (flags_b),
        .cond      (cmd_word.cond),
        .predicate (predicate)
    );

    branch_resolve u_branch_resolve (
        .clock            (clock),
        .arst_n           (arst_n),
        .eval             (eval),
        .predicate        (predicate),
        .target           (cmd_word.cond.target),
        .branch_taken     (branch_taken),
        .branch_not_taken (branch_not_taken),
        .branch_target    (branch_target)
    );

endmodule

`default_nettype wire

// File: branch_resolve.sv
`timescale 1ns/1ns
`default_nettype none

`include "bcu_cfg.svh"

module branch_resolve (
    input  logic                         clock,
    input  logic                         arst_n,
    input  logic                         eval,
    input  logic                         predicate,
    input  logic [`BCU_TARGET_WIDTH-1:0] target,
    output logic                         branch_taken,
    output logic                         branch_not_taken,
    output logic [`BCU_TARGET_WIDTH-1:0] branch_target
);

    // ------------------------------------------------------------
    // decision pulses
    // ------------------------------------------------------------

    // every eval gives exactly one pulse in the following cycle,
    // and with no eval both pulses drop back low
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            branch_taken     <= 1'b0;
            branch_not_taken <= 1'b0;
        end else begin
            branch_taken     <= eval & predicate;
            branch_not_taken <= eval & ~predicate;
        end
    end

    // ------------------------------------------------------------
    // target register
    // ------------------------------------------------------------

    // the target is valid alongside the pulse and then holds
    // until the next eval replaces it
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            branch_target <= '0;
        end else if (eval) begin
            branch_target <= target;
        end
    end

endmodule

`default_nettype wire

// File: condition_predicate.sv
`timescale 1ns/1ns
`default_nettype none

`include "bcu_cfg.svh"

module condition_predicate
    import bcu_pkg::*;
(
    input  flags_a_t     flags_a,
    input  flags_b_t     flags_b,
    input  cond_fields_t cond,
    output logic         predicate
);

    // one flag from each group feeds the truth table, so every signed and
    // unsigned compare is reachable, as are mixes of sentinel matches,
    // the timer and the external levels

    logic [(1 << `BCU_SELECTOR_WIDTH)-1:0] group_a;
    logic [(1 << `BCU_SELECTOR_WIDTH)-1:0] group_b;
    logic                                  selected_a;
    logic                                  selected_b;

    // ------------------------------------------------------------
    // flag selection
    // ------------------------------------------------------------

    // the structs are laid out so that bit n is selector value n
    assign group_a = flags_a;
    assign group_b = flags_b;

    assign selected_a = group_a[cond.a_sel];
    assign selected_b = group_b[cond.b_sel];

    // ------------------------------------------------------------
    // truth-table combiner
    // ------------------------------------------------------------

    // op bit 2*a + b gives the result for that pair of inputs,
    // e.g. 4'b1100 passes a through and 4'b1010 passes b through
    assign predicate = cond.op[{selected_a, selected_b}];

endmodule

`default_nettype wire

// File: flag_capture.sv
`timescale 1ns/1ns
`default_nettype none

`include "bcu_cfg.svh"

module flag_capture
    import bcu_pkg::*;
(
    input  logic                       clock,
    input  logic                       arst_n,
    input  logic                       alu_valid,
    input  logic [`BCU_WORD_WIDTH-1:0] alu_result,
    input  logic                       alu_carryout,
    input  logic                       alu_overflow,
    input  logic                       ext_a,
    input  logic                       ext_b,
    input  logic                       load_counter,
    input  logic                       load_sentinel_a,
    input  logic                       load_sentinel_b,
    input  logic [`BCU_WORD_WIDTH-1:0] load_value,
    output flags_a_t                   flags_a,
    output flags_b_t                   flags_b
);

    logic [`BCU_WORD_WIDTH-1:0]    sentinel_a;
    logic [`BCU_WORD_WIDTH-1:0]    sentinel_b;
    logic [`BCU_COUNTER_WIDTH-1:0] counter;
    logic [`BCU_COUNTER_WIDTH-1:0] counter_next;
    logic                          negative;
    logic                          carryout;
    logic                          lessthan;
    logic                          match_a;
    logic                          match_b;
    logic                          counter_zero;

    // ------------------------------------------------------------
    // sentinel registers
    // ------------------------------------------------------------

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            sentinel_a <= '0;
            sentinel_b <= '0;
        end else begin
            if (load_sentinel_a) begin
                sentinel_a <= load_value;
            end
            if (load_sentinel_b) begin
                sentinel_b <= load_value;
            end
        end
    end

    // ------------------------------------------------------------
    // ALU flags, taken from the result of the previous instruction
    // ------------------------------------------------------------

    // the matches compare against the sentinels held at this edge,
    // so a sentinel load in the same cycle only affects later results
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            negative <= 1'b0;
            carryout <= 1'b0;
            lessthan <= 1'b0;
            match_a  <= 1'b0;
            match_b  <= 1'b0;
        end else if (alu_valid) begin
            negative <= alu_result[`BCU_WORD_WIDTH-1];
            carryout <= alu_carryout;
            // signed less-than after a subtract is negative xor overflow
            lessthan <= alu_result[`BCU_WORD_WIDTH-1] ^ alu_overflow;
            match_a  <= (alu_result == sentinel_a);
            match_b  <= (alu_result == sentinel_b);
        end
    end

    // ------------------------------------------------------------
    // countdown timer
    // ------------------------------------------------------------

    // a load wins over the decrement, and the count parks at zero
    always_comb begin
        if (load_counter) begin
            counter_next = load_value;
        end else if (counter != '0) begin
            counter_next = counter - `BCU_COUNTER_WIDTH'(1);
        end else begin
            counter_next = counter;
        end
    end

    // the zero flag is registered alongside the count itself
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            counter      <= '0;
            counter_zero <= 1'b1;
        end else begin
            counter      <= counter_next;
            counter_zero <= (counter_next == '0);
        end
    end

    // external inputs are levels and go straight into the groups
    always_comb begin
        flags_a.negative = negative;
        flags_a.carryout = carryout;
        flags_a.sentinel = match_a;
        flags_a.external = ext_a;
        flags_b.lessthan = lessthan;
        flags_b.counter  = counter_zero;
        flags_b.sentinel = match_b;
        flags_b.external = ext_b;
    end

endmodule

`default_nettype wire

// File: bcu_pkg.sv
`default_nettype none

`include "bcu_cfg.svh"

package bcu_pkg;

    // ------------------------------------------------------------
    // command kinds, carried beside the command word
    // ------------------------------------------------------------

    typedef enum logic [1:0] {
        EVAL            = 2'd0,
        LOAD_COUNTER    = 2'd1,
        LOAD_SENTINEL_A = 2'd2,
        LOAD_SENTINEL_B = 2'd3
    } cmd_kind_e;

    // field layout of an eval command, most significant field first
    typedef struct packed {
        logic [`BCU_SELECTOR_WIDTH-1:0] a_sel;
        logic [`BCU_SELECTOR_WIDTH-1:0] b_sel;
        logic [`BCU_OPERATOR_WIDTH-1:0] op;
        logic [`BCU_TARGET_WIDTH-1:0]   target;
    } cond_fields_t;

    // the same 16 bits read as condition fields for EVAL
    // and as a plain value for the three load kinds
    typedef union packed {
        cond_fields_t                cond;
        logic [`BCU_WORD_WIDTH-1:0] payload;
    } cmd_word_u;

    // ------------------------------------------------------------
    // flag groups, declared MSB first so bit n is selector index n
    // ------------------------------------------------------------

    typedef struct packed {
        logic external;
        logic sentinel;
        logic carryout;
        logic negative;
    } flags_a_t;

    typedef struct packed {
        logic external;
        logic sentinel;
        logic counter;
        logic lessthan;
    } flags_b_t;

endpackage

`default_nettype wire

// File: bcu_cfg.svh
`ifndef BCU_CFG_SVH
`define BCU_CFG_SVH

// width of the ALU result, of both sentinel registers and of the command word
`define BCU_WORD_WIDTH 16

// each selector picks one of four flags in its group
`define BCU_SELECTOR_WIDTH 2

// truth-table operator, one bit per combination of the two selected flags
`define BCU_OPERATOR_WIDTH 4

// branch target carried in the low byte of an eval command
`define BCU_TARGET_WIDTH 8

// countdown timer width, loaded straight from the command payload
`define BCU_COUNTER_WIDTH 16

`endif
